// ==== sim.f ====
+incdir+include
source/aggPipePkg.sv
source/leafEliminator.sv
source/graphProducer.sv
source/graphFifo.sv
source/componentCounter.sv
source/batchAccumulator.sv
source/aggregatingPipeline.sv
tb/aggregatingPipeline_assertions.sv
tb/aggregatingPipeline_tb.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = aggregatingPipeline_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
PASS_MSG = Done: no errors

.PHONY: sim clean

# the run passes only if the pass message shows up as a line of its own
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/aggregatingPipeline_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aggPipe_cfg.svh"

module aggregatingPipeline_tb;

    import aggPipePkg::*;

    localparam int NumRandom = 24;
    localparam int MaxDelay = 3;
    localparam int WorstGraphCycles = 2 * `GRAPH_BITS + 40;  // all components plus handshakes

    typedef struct packed {
        graphT top;
        graphT bot;
        logic lastOfBatch;
    } stimT;

    typedef struct packed {
        pcoeffSumT sum;
        batchCountT graphs;
    } resultT;

    logic clk;
    logic arstN;
    logic inReq;
    logic inAck;
    graphT top;
    graphT bot;
    logic lastOfBatch;
    logic resultsValid;
    pcoeffSumT pcoeffSum;
    batchCountT pcoeffCount;

    stimT rowStim[$];
    int rowDelay[$];
    resultT expResults[$];  // one entry per batch, in report order
    string expNames[$];
    pcoeffSumT batchSum;
    batchCountT batchGraphs;
    int batchTotal;
    int resultsSeen;
    int checkCount;
    int errorCount;
    logic [31:0] rngState;

    aggregatingPipeline aggregatingPipeline_i (
        .clk(clk),
        .arstN(arstN),
        .inReq(inReq),
        .inAck(inAck),
        .top(top),
        .bot(bot),
        .lastOfBatch(lastOfBatch),
        .resultsValid(resultsValid),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // plain BFS over the cube, no leaf removal
    function automatic int countComponentsRef(input graphT g);
        bit seen [`GRAPH_BITS];
        int frontier [$];
        int comps;
        int node;
        int nbr;
        comps = 0;
        for (int n = 0; n < `GRAPH_BITS; n++) seen[n] = 1'b0;
        for (int n = 0; n < `GRAPH_BITS; n++) begin
            if (g[n] && !seen[n]) begin
                comps++;
                seen[n] = 1'b1;
                frontier.push_back(n);
                while (frontier.size() > 0) begin
                    node = frontier.pop_front();
                    for (int d = 0; d < `CUBE_DIM; d++) begin
                        nbr = node ^ (1 << d);
                        if (g[nbr] && !seen[nbr]) begin
                            seen[nbr] = 1'b1;
                            frontier.push_back(nbr);
                        end
                    end
                end
            end
        end
        return comps;
    endfunction

    task automatic compareValue(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic addRow(input string name, input graphT t, input graphT b,
                          input logic last, input int delay);
        int comps;
        comps = countComponentsRef(t & ~b);
        rowStim.push_back('{top: t, bot: b, lastOfBatch: last});
        rowDelay.push_back(delay);
        batchSum = batchSum + (pcoeffSumT'(1) << comps);
        batchGraphs = batchGraphs + 1'b1;
        if (last) begin
            expResults.push_back('{sum: batchSum, graphs: batchGraphs});
            expNames.push_back(name);
            batchTotal++;
            batchSum = '0;
            batchGraphs = '0;
        end
    endtask

    task automatic buildTable();
        graphT t;
        graphT b;
        logic [31:0] r1;
        logic last;
        batchSum = '0;
        batchGraphs = '0;
        addRow("empty0", '0, '0, 1'b0, 1);
        addRow("empty1", '0, '0, 1'b0, 0);
        addRow("empty2", '0, '0, 1'b1, 0);
        t = '0;
        for (int n = 0; n < `GRAPH_BITS; n++) t[n] = ~(^n[6:0]);  // even parity, 64 singletons
        addRow("isolated", t, '0, 1'b1, 2);
        addRow("fullCube", '1, '0, 1'b0, 0);
        t = '0;
        t[0] = 1'b1;
        t[127] = 1'b1;
        t[5] = 1'b1;
        t[122] = 1'b1;
        addRow("antipodal", t, '0, 1'b1, 0);
        t = '0;
        t[0] = 1'b1;
        t[1] = 1'b1;
        addRow("pair", t, '0, 1'b0, 0);
        t[3] = 1'b1;  // chain 0-1-3-7-15 and pair 96-112
        t[7] = 1'b1;
        t[15] = 1'b1;
        t[96] = 1'b1;
        t[112] = 1'b1;
        addRow("chain", t, '0, 1'b0, 0);
        b = '1;
        b[8] = 1'b0;
        b[9] = 1'b0;
        b[11] = 1'b0;
        addRow("maskedPath", '1, b, 1'b1, 0);
        rngState = 32'd6;
        for (int r = 0; r < NumRandom; r++) begin
            for (int w = 0; w < `GRAPH_BITS / 32; w++) begin
                rngState = xorshift32(rngState);
                t[w*32 +: 32] = rngState;
                rngState = xorshift32(rngState);
                r1 = rngState;
                rngState = xorshift32(rngState);
                b[w*32 +: 32] = r1 & rngState;
            end
            rngState = xorshift32(rngState);
            last = (rngState[3:2] == 2'b00) || (r == NumRandom - 1);
            addRow($sformatf("random%0d", r), t, b, last,
                   (r < 12) ? 0 : int'(rngState[1:0]));  // first rows back to back
        end
    endtask

    task automatic sendRow(input int i);
        repeat (rowDelay[i]) @(posedge clk);
        @(posedge clk);
        top <= rowStim[i].top;
        bot <= rowStim[i].bot;
        lastOfBatch <= rowStim[i].lastOfBatch;
        inReq <= 1'b1;
        do @(negedge clk); while (inAck !== 1'b1);
        @(posedge clk);
        inReq <= 1'b0;
        do @(negedge clk); while (inAck !== 1'b0);
    endtask

    task automatic watchdog();
        int limit;
        limit = rowStim.size() * (WorstGraphCycles + MaxDelay) + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: only %0d of %0d batch results seen after %0d cycles",
                 resultsSeen, batchTotal, limit);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Done: errors found");
        $finish;
    endtask

    // results sampled mid-cycle, away from the clock edge
    initial begin : resultMonitor
        resultT expected;
        string name;
        forever begin
            @(negedge clk);
            if (resultsValid === 1'b1) begin
                if (expResults.size() == 0) begin
                    errorCount++;
                    $display("a result was reported with no batch outstanding");
                end else begin
                    expected = expResults.pop_front();
                    name = expNames.pop_front();
                    compareValue({name, " sum"}, 128'(expected.sum), 128'(pcoeffSum));
                    compareValue({name, " count"}, 128'(expected.graphs), 128'(pcoeffCount));
                end
                resultsSeen++;
            end
        end
    end

    initial begin : mainFlow
        arstN <= 1'b0;
        inReq <= 1'b0;
        top <= '0;
        bot <= '0;
        lastOfBatch <= 1'b0;
        buildTable();
        fork
            watchdog();
        join_none
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        compareValue("resetInAck", 128'(1'b0), 128'(inAck));
        compareValue("resetResultsValid", 128'(1'b0), 128'(resultsValid));
        for (int i = 0; i < rowStim.size(); i++) sendRow(i);
        while (resultsSeen < batchTotal) @(negedge clk);
        repeat (4) @(negedge clk);  // catch any extra report
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/aggregatingPipeline_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module aggregatingPipeline_assertions (
    input wire logic clk,
    input wire logic arstN,
    input wire logic inReq,
    input wire logic inAck,
    input wire logic prodReq,
    input wire logic prodAck,
    input wire logic fifoReq,
    input wire logic fifoAck,
    input wire aggPipePkg::compCountT count
);

    // a request stays up until it is acknowledged
    inReqHeld: assert property (@(posedge clk) disable iff (!arstN)
        inReq && !inAck |=> inReq)
        else $error("inReq dropped before inAck");
    prodReqHeld: assert property (@(posedge clk) disable iff (!arstN)
        prodReq && !prodAck |=> prodReq)
        else $error("prodReq dropped before prodAck");
    fifoReqHeld: assert property (@(posedge clk) disable iff (!arstN)
        fifoReq && !fifoAck |=> fifoReq)
        else $error("fifoReq dropped before fifoAck");

    inAckNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(inAck) |-> inReq)
        else $error("inAck rose without inReq");
    prodAckNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(prodAck) |-> prodReq)
        else $error("prodAck rose without prodReq");
    fifoAckNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(fifoAck) |-> fifoReq)
        else $error("fifoAck rose without fifoReq");

    // a 7-cube splits into at most 64 components
    countInRange: assert property (@(posedge clk) disable iff (!arstN)
        count <= 7'd64)
        else $error("component count above 64");

endmodule

bind aggregatingPipeline aggregatingPipeline_assertions aggregatingPipeline_assertions_i (
    .clk(clk),
    .arstN(arstN),
    .inReq(inReq),
    .inAck(inAck),
    .prodReq(prodReq),
    .prodAck(prodAck),
    .fifoReq(fifoReq),
    .fifoAck(fifoAck),
    .count(count)
);

`default_nettype wire

// ==== source/aggregatingPipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module aggregatingPipeline (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic inReq,
    output logic inAck,
    input  wire aggPipePkg::graphT top,
    input  wire aggPipePkg::graphT bot,
    input  wire logic lastOfBatch,
    output logic resultsValid,
    output aggPipePkg::pcoeffSumT pcoeffSum,
    output aggPipePkg::batchCountT pcoeffCount
);

    import aggPipePkg::*;

    logic prodReq;
    logic prodAck;
    graphItemT prodItem;  // leaf-eliminated graph
    logic fifoReq;
    logic fifoAck;
    graphItemT fifoItem;
    logic countValid;
    compCountT count;
    logic countLast;

    graphProducer graphProducer_i (
        .clk(clk),
        .arstN(arstN),
        .inReq(inReq),
        .inAck(inAck),
        .top(top),
        .bot(bot),
        .lastOfBatch(lastOfBatch),
        .prodReq(prodReq),
        .prodAck(prodAck),
        .prodItem(prodItem)
    );

    graphFifo graphFifo_i (
        .clk(clk),
        .arstN(arstN),
        .prodReq(prodReq),
        .prodAck(prodAck),
        .prodItem(prodItem),
        .fifoReq(fifoReq),
        .fifoAck(fifoAck),
        .fifoItem(fifoItem)
    );

    componentCounter componentCounter_i (
        .clk(clk),
        .arstN(arstN),
        .fifoReq(fifoReq),
        .fifoAck(fifoAck),
        .fifoItem(fifoItem),
        .countValid(countValid),
        .count(count),
        .countLast(countLast)
    );

    batchAccumulator batchAccumulator_i (
        .clk(clk),
        .arstN(arstN),
        .countValid(countValid),
        .count(count),
        .countLast(countLast),
        .resultsValid(resultsValid),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

endmodule

`default_nettype wire

// ==== source/batchAccumulator.sv ====
`timescale 1ns/1ns
`default_nettype none

module batchAccumulator (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic countValid,
    input  wire aggPipePkg::compCountT count,
    input  wire logic countLast,
    output logic resultsValid,
    output aggPipePkg::pcoeffSumT pcoeffSum,
    output aggPipePkg::batchCountT pcoeffCount
);

    import aggPipePkg::*;

    pcoeffT pcoeff;
    pcoeffSumT sumAcc;  // running sum of the open batch
    pcoeffSumT sumNext;
    batchCountT graphsAcc;
    batchCountT graphsNext;

    assign pcoeff = pcoeffT'(1) << count;
    assign sumNext = sumAcc + pcoeffSumT'(pcoeff);
    assign graphsNext = graphsAcc + 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultsValid <= 1'b0;
            sumAcc <= '0;
            graphsAcc <= '0;
            pcoeffSum <= '0;
            pcoeffCount <= '0;
        end else begin
            resultsValid <= 1'b0;
            if (countValid) begin
                if (countLast) begin
                    // report totals including this graph, start a fresh batch
                    resultsValid <= 1'b1;
                    pcoeffSum <= sumNext;
                    pcoeffCount <= graphsNext;
                    sumAcc <= '0;
                    graphsAcc <= '0;
                end else begin
                    sumAcc <= sumNext;
                    graphsAcc <= graphsNext;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/componentCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aggPipe_cfg.svh"

module componentCounter (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic fifoReq,
    output logic fifoAck,
    input  wire aggPipePkg::graphItemT fifoItem,
    output logic countValid,
    output aggPipePkg::compCountT count,
    output logic countLast
);

    import aggPipePkg::*;

    countStateT state;
    graphT remaining;  // nodes not yet in a counted component
    graphT reach;      // component grown so far
    graphT grown;
    logic accept;
    logic settled;

    // every node with at least one member of g among its cube neighbors
    function automatic graphT cubeNeighbors(input graphT g);
        graphT nb;
        nb = '0;
        for (int d = 0; d < `CUBE_DIM; d++) begin
            for (int n = 0; n < `GRAPH_BITS; n++) begin
                nb[n] = nb[n] | g[n ^ (1 << d)];
            end
        end
        return nb;
    endfunction

    assign accept = (state == countIdle) && fifoReq && !fifoAck;
    assign grown = reach | (cubeNeighbors(reach) & remaining);
    assign settled = (grown == reach);  // flood fill reached its fixed point
    assign countValid = (state == countDone);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= countIdle;
            fifoAck <= 1'b0;
            count <= '0;
            countLast <= 1'b0;
        end else begin
            // ack drops on its own once the FIFO releases req
            if (fifoAck && !fifoReq) fifoAck <= 1'b0;

            case (state)
                countIdle: begin
                    if (accept) begin
                        fifoAck <= 1'b1;
                        countLast <= fifoItem.lastOfBatch;
                        count <= '0;
                        state <= countSeed;
                    end
                end
                countSeed: begin
                    if (remaining == '0) begin
                        state <= countDone;
                    end else begin
                        state <= countGrow;
                    end
                end
                countGrow: begin
                    if (settled) begin
                        count <= count + 1'b1;
                        state <= countSeed;
                    end
                end
                countDone: state <= countIdle;  // countValid high for this cycle
                default: state <= countIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            remaining <= fifoItem.graph;
        end else if (state == countSeed) begin
            reach <= remaining & (~remaining + 1'b1);  // lowest remaining node
        end else if (state == countGrow) begin
            reach <= grown;
            if (settled) remaining <= remaining & ~reach;
        end
    end

endmodule

`default_nettype wire

// ==== source/graphFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aggPipe_cfg.svh"

module graphFifo (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic prodReq,
    output logic prodAck,
    input  wire aggPipePkg::graphItemT prodItem,
    output logic fifoReq,
    input  wire logic fifoAck,
    output aggPipePkg::graphItemT fifoItem
);

    import aggPipePkg::*;

    localparam logic [`FIFO_PTR_BITS-1:0] LastSlot = `FIFO_PTR_BITS'(`FIFO_DEPTH - 1);
    localparam logic [`FIFO_PTR_BITS:0] FullCount = (`FIFO_PTR_BITS + 1)'(`FIFO_DEPTH);

    graphItemT mem [`FIFO_DEPTH];
    logic [`FIFO_PTR_BITS-1:0] wrPtr;
    logic [`FIFO_PTR_BITS-1:0] rdPtr;
    logic [`FIFO_PTR_BITS:0] used;  // occupancy
    hsStateT wrState;
    hsStateT rdState;
    logic push;
    logic pop;

    assign push = (wrState == hsIdle) && prodReq && (used != FullCount);
    assign pop = (rdState == hsWaitRelease) && !fifoAck;  // entry leaves on ack fall

    // head entry stays put until popped, so it is stable while fifoReq is up
    assign fifoItem = mem[rdPtr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrState <= hsIdle;
            rdState <= hsIdle;
            prodAck <= 1'b0;
            fifoReq <= 1'b0;
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else begin
            case (wrState)
                hsIdle: begin
                    if (push) begin
                        prodAck <= 1'b1;
                        wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
                        wrState <= hsWaitRelease;
                    end
                end
                hsWaitRelease: begin
                    if (!prodReq) begin
                        prodAck <= 1'b0;
                        wrState <= hsIdle;
                    end
                end
                default: wrState <= hsIdle;
            endcase

            case (rdState)
                hsIdle: begin
                    if (used != '0) begin
                        fifoReq <= 1'b1;
                        rdState <= hsWaitAck;
                    end
                end
                hsWaitAck: begin
                    if (fifoAck) begin
                        fifoReq <= 1'b0;
                        rdState <= hsWaitRelease;
                    end
                end
                hsWaitRelease: begin
                    if (pop) begin
                        rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
                        rdState <= hsIdle;
                    end
                end
                default: rdState <= hsIdle;
            endcase

            case ({push, pop})
                2'b10: used <= used + 1'b1;
                2'b01: used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= prodItem;
    end

endmodule

`default_nettype wire

// ==== source/graphProducer.sv ====
`timescale 1ns/1ns
`default_nettype none

module graphProducer (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic inReq,
    output logic inAck,
    input  wire aggPipePkg::graphT top,
    input  wire aggPipePkg::graphT bot,
    input  wire logic lastOfBatch,
    output logic prodReq,
    input  wire logic prodAck,
    output aggPipePkg::graphItemT prodItem
);

    import aggPipePkg::*;

    graphT formed;
    graphT pruned;
    hsStateT inState;
    hsStateT outState;  // not idle while the slot holds an item
    logic capture;

    assign formed = top & ~bot;  // blocked nodes removed

    leafEliminator leafEliminator_i (
        .graphIn(formed),
        .graphOut(pruned)
    );

    assign capture = (inState == hsIdle) && inReq && (outState == hsIdle);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inState <= hsIdle;
            outState <= hsIdle;
            inAck <= 1'b0;
            prodReq <= 1'b0;
        end else begin
            case (inState)
                hsIdle: begin
                    if (capture) begin
                        inAck <= 1'b1;
                        inState <= hsWaitRelease;
                    end
                end
                hsWaitRelease: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        inState <= hsIdle;
                    end
                end
                default: inState <= hsIdle;
            endcase

            case (outState)
                hsIdle: begin
                    if (capture) begin
                        prodReq <= 1'b1;  // same cycle as inAck
                        outState <= hsWaitAck;
                    end
                end
                hsWaitAck: begin
                    if (prodAck) begin
                        prodReq <= 1'b0;
                        outState <= hsWaitRelease;
                    end
                end
                hsWaitRelease: begin
                    if (!prodAck) outState <= hsIdle;  // slot free again
                end
                default: outState <= hsIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            prodItem.graph <= pruned;
            prodItem.lastOfBatch <= lastOfBatch;
        end
    end

endmodule

`default_nettype wire

// ==== source/leafEliminator.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aggPipe_cfg.svh"

module leafEliminator (
    input  wire aggPipePkg::graphT graphIn,
    output aggPipePkg::graphT graphOut
);

    // A node is a leaf when exactly one of its seven cube neighbors is set.
    // Only leaves whose single neighbor sits at a lower index are cleared, so
    // the surviving neighbor is never itself removed in the same pass and the
    // component count is unchanged.
    for (genvar n = 0; n < `GRAPH_BITS; n++) begin : genNode
        // bits of n that are set point to lower-index neighbors
        localparam logic [`CUBE_DIM-1:0] LowerDims = `CUBE_DIM'(n);

        logic [`CUBE_DIM-1:0] nbrSet;  // neighbor present, per dimension
        logic [`CUBE_DIM-1:0] nbrRest;
        logic singleNbr;
        logic downLeaf;

        for (genvar d = 0; d < `CUBE_DIM; d++) begin : genDim
            assign nbrSet[d] = graphIn[n ^ (1 << d)];
        end

        assign nbrRest = nbrSet & (nbrSet - 1'b1);  // drops lowest set dim
        assign singleNbr = (nbrSet != '0) && (nbrRest == '0);
        assign downLeaf = singleNbr && ((nbrSet & LowerDims) != '0);

        assign graphOut[n] = graphIn[n] & ~downLeaf;
    end

endmodule

`default_nettype wire

// ==== source/aggPipePkg.sv ====
`default_nettype none

`include "aggPipe_cfg.svh"

package aggPipePkg;

    typedef logic [`GRAPH_BITS-1:0] graphT;                         // node set
    typedef logic [`COUNT_BITS-1:0] compCountT;                     // 0 to 64
    typedef logic [`PCOEFF_BITS-1:0] pcoeffT;                       // 2**count
    typedef logic [`PCOEFF_BITS+`BATCH_COUNT_BITS-1:0] pcoeffSumT;  // batch sum
    typedef logic [`BATCH_COUNT_BITS-1:0] batchCountT;

    typedef struct packed {
        logic lastOfBatch;
        graphT graph;
    } graphItemT;

    // one side of a four-phase link
    typedef enum logic [1:0] {
        hsIdle,
        hsWaitAck,
        hsWaitRelease
    } hsStateT;

    typedef enum logic [1:0] {
        countIdle,
        countSeed,
        countGrow,
        countDone
    } countStateT;

endpackage

`default_nettype wire

// ==== include/aggPipe_cfg.svh ====
`ifndef AGGPIPE_CFG_SVH
`define AGGPIPE_CFG_SVH

// one node per bit of the input word
`define GRAPH_BITS 128
`define CUBE_DIM 7

// fifo between producer and counter
`define FIFO_DEPTH 4
`define FIFO_PTR_BITS 2

// component count never exceeds 64 on a 7-cube
`define COUNT_BITS 7
`define PCOEFF_BITS 65

// graphs per batch
`define BATCH_COUNT_BITS 16

`endif
